/* ahb_in_stage.f */
+incdir+verilog
verilog/ahb_in_pkg.sv
verilog/ahb_in_hold_reg.sv
verilog/ahb_in_tran_ctrl.sv
verilog/ahb_in_burst_fix.sv
verilog/ahb_in_stage.sv
tests/tb_clk_gen.sv
tests/tb_checker.sv
tests/tb_ahb_in_stage.sv

/* tests/ahb_in_vectors.txt */
# name sel addr trans write size burst prot master lock hready active readyout resp
# then expected: hreadyout hresp sel addr trans write burst master held (all hex)
reset_idle          0 00000000 0 0 2 0 0 0 0 1 1 1 0  1 0 0 00000000 0 0 0 0 0
pass_nseq           1 00001000 2 1 2 0 3 1 0 1 1 1 0  1 0 1 00001000 2 1 0 1 1
pass_data           1 00002000 2 0 2 0 3 1 0 1 1 1 0  1 0 1 00002000 2 0 0 1 1
resp_wait           0 00000000 0 0 2 0 0 0 0 0 1 0 0  0 0 0 00000000 0 0 0 0 0
resp_error1         0 00000000 0 0 2 0 0 0 0 0 1 0 1  0 1 0 00000000 0 0 0 0 0
resp_error2         0 00000000 0 0 2 0 0 0 0 1 1 1 1  1 1 0 00000000 0 0 0 0 0
idle_okay           0 00000000 0 0 2 0 0 0 0 1 1 0 0  1 0 0 00000000 0 0 0 0 0
hold_load           1 00003004 2 1 2 0 2 5 1 1 0 0 0  1 0 1 00003004 2 1 0 5 1
hold_wait           0 00000000 0 0 2 0 0 0 0 0 0 0 0  0 0 1 00003004 2 1 0 5 1
hold_grant          0 00000000 0 0 2 0 0 0 0 0 1 0 0  0 0 1 00003004 2 1 0 5 1
hold_accept         0 00000000 0 0 2 0 0 0 0 0 1 1 0  0 0 1 00003004 2 1 0 5 1
hold_release        0 00000000 0 0 2 0 0 0 0 1 1 1 0  1 0 0 00000000 0 0 0 0 0
wrap_nseq           1 00000018 2 0 2 2 0 2 0 1 1 1 0  1 0 1 00000018 2 0 2 2 1
wrap_seq_lost       1 0000001C 3 0 2 2 0 2 0 1 0 1 0  1 0 1 0000001C 3 0 2 2 1
wrap_held           1 00000010 3 0 2 2 0 2 0 0 1 1 0  0 0 1 0000001C 2 0 1 2 1
wrap_busy           1 00000010 1 0 2 2 0 2 0 1 1 1 0  1 0 1 00000010 0 0 1 2 0
wrap_seq_after_busy 1 00000010 3 0 2 2 0 2 0 1 1 1 0  1 0 1 00000010 2 0 1 2 1
wrap_seq_inner      1 00000014 3 0 2 2 0 2 0 1 1 1 0  1 0 1 00000014 3 0 1 2 1
burst_end_idle      0 00000000 0 0 2 0 0 0 0 1 1 1 0  1 0 0 00000000 0 0 1 0 0
after_idle          0 00000000 0 0 2 0 0 0 0 1 1 1 0  1 0 0 00000000 0 0 0 0 0
w8_nseq             1 00000038 2 1 2 4 0 3 0 1 1 1 0  1 0 1 00000038 2 1 4 3 1
w8_seq_lost         1 0000003C 3 1 2 4 0 3 0 1 0 1 0  1 0 1 0000003C 3 1 4 3 1
w8_held             1 00000020 3 1 2 4 0 3 0 0 1 1 0  0 0 1 0000003C 2 1 1 3 1
w8_restart          1 00000020 3 1 2 4 0 3 0 1 1 1 0  1 0 1 00000020 2 1 1 3 1
w8_nseq_clear       1 00000040 2 0 2 1 0 3 0 1 1 1 0  1 0 1 00000040 2 0 1 3 1
incr_seq_lost       1 0000003C 3 0 2 1 0 3 0 1 0 1 0  1 0 1 0000003C 3 0 1 3 1
incr_held           1 00000040 3 0 2 1 0 3 0 0 1 1 0  0 0 1 0000003C 2 0 1 3 1
incr_seq            1 00000040 3 0 2 1 0 3 0 1 1 1 0  1 0 1 00000040 3 0 1 3 1
final_idle          0 00000000 0 0 2 0 0 0 0 1 1 1 0  1 0 0 00000000 0 0 1 0 0
end_idle            0 00000000 0 0 2 0 0 0 0 1 1 1 0  1 0 0 00000000 0 0 0 0 0

/* tests/tb_ahb_in_stage.sv */
`default_nettype none

`include "ahb_in_macros.svh"

// Vector driven testbench of the slave port input stage
module tb_ahb_in_stage
  import ahb_in_pkg::*;
();

  localparam int MAX_VEC = 64;
  localparam int NFIELD  = 22;   // Columns after the name

  wire                      HCLK;
  wire                      HRESETn;
  logic                     hsel_s, hwrite_s, hmastlock_s, hready_s;
  logic [`AHB_ADDR_W-1:0]   haddr_s;
  htrans_t                  htrans_s;
  logic [`AHB_SIZE_W-1:0]   hsize_s;
  hburst_t                  hburst_s;
  logic [`AHB_PROT_W-1:0]   hprot_s;
  logic [`AHB_MASTER_W-1:0] hmaster_s;
  logic                     active_ip, readyout_ip;
  hresp_t                   resp_ip;
  wire                      hreadyout_s, sel_ip, write_ip, mastlock_ip, held_tran_ip;
  hresp_t                   hresp_s;
  wire [`AHB_ADDR_W-1:0]    addr_ip;
  htrans_t                  trans_ip;
  hburst_t                  burst_ip;
  wire [`AHB_SIZE_W-1:0]    size_ip;
  wire [`AHB_PROT_W-1:0]    prot_ip;
  wire [`AHB_MASTER_W-1:0]  master_ip;

  // Expected values toward the checker
  logic                     check_en;
  logic [8*24-1:0]          test_name;
  logic                     exp_hreadyout, exp_sel, exp_write, exp_held;
  logic [1:0]               exp_hresp, exp_trans;
  logic [31:0]              exp_addr;
  logic [2:0]               exp_burst;
  logic [3:0]               exp_master;
  logic [`AHB_SIZE_W-1:0]   exp_size;
  logic [`AHB_PROT_W-1:0]   exp_prot;
  logic                     exp_lock;

  // Vector storage
  logic [8*24-1:0]  v_name [0:MAX_VEC-1];
  logic [31:0]      v_f    [0:MAX_VEC-1][0:NFIELD-1];
  integer           nvec = 0;
  logic             vectors_loaded = 1'b0;

  tb_clk_gen u_clk_gen (.HCLK(HCLK), .HRESETn(HRESETn));

  ahb_in_stage DUT (
    .HCLK(HCLK), .HRESETn(HRESETn), .hsel_s(hsel_s), .haddr_s(haddr_s),
    .htrans_s(htrans_s), .hwrite_s(hwrite_s), .hsize_s(hsize_s), .hburst_s(hburst_s),
    .hprot_s(hprot_s), .hmaster_s(hmaster_s), .hmastlock_s(hmastlock_s),
    .hready_s(hready_s), .active_ip(active_ip), .readyout_ip(readyout_ip),
    .resp_ip(resp_ip), .hreadyout_s(hreadyout_s), .hresp_s(hresp_s), .sel_ip(sel_ip),
    .addr_ip(addr_ip), .trans_ip(trans_ip), .write_ip(write_ip), .size_ip(size_ip),
    .burst_ip(burst_ip), .prot_ip(prot_ip), .master_ip(master_ip),
    .mastlock_ip(mastlock_ip), .held_tran_ip(held_tran_ip)
  );

  tb_checker u_checker (
    .HCLK(HCLK), .check_en(check_en), .test_name(test_name),
    .exp_hreadyout(exp_hreadyout), .exp_hresp(exp_hresp), .exp_sel(exp_sel),
    .exp_addr(exp_addr), .exp_trans(exp_trans), .exp_write(exp_write),
    .exp_size(exp_size), .exp_burst(exp_burst), .exp_prot(exp_prot),
    .exp_master(exp_master), .exp_lock(exp_lock), .exp_held(exp_held),
    .hreadyout_s(hreadyout_s), .hresp_s(hresp_s), .sel_ip(sel_ip), .addr_ip(addr_ip),
    .trans_ip(trans_ip), .write_ip(write_ip), .size_ip(size_ip), .burst_ip(burst_ip),
    .prot_ip(prot_ip), .master_ip(master_ip), .mastlock_ip(mastlock_ip),
    .held_tran_ip(held_tran_ip)
  );

  // ------------------------------------------------
  // Vector reader
  // ------------------------------------------------
  task automatic read_vectors;
    integer           fd;
    integer           code;
    integer           k;
    logic [8*256-1:0] line;
    logic [8*24-1:0]  name;
    logic [31:0]      t [0:NFIELD-1];
    fd = $fopen("tests/ahb_in_vectors.txt", "r");
    if (fd == 0)
      u_checker.report_problem("vector file tests/ahb_in_vectors.txt could not be opened");
    else
    begin
      while (!$feof(fd) && nvec < MAX_VEC)
      begin
        line = '0;
        name = '0;
        code = $fgets(line, fd);
        code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       name, t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7], t[8], t[9],
                       t[10], t[11], t[12], t[13], t[14], t[15], t[16], t[17], t[18],
                       t[19], t[20], t[21]);
        if (code == NFIELD + 1)
        begin
          v_name[nvec] = name;
          for (k = 0; k < NFIELD; k = k + 1)
            v_f[nvec][k] = t[k];
          nvec = nvec + 1;
        end
        else if (code >= 2 || (code == 1 && name != "#"))
          u_checker.report_problem("vector file has a line with too few columns");
      end
      $fclose(fd);
      if (nvec == 0)
        u_checker.report_problem("vector file holds no test vectors");
    end
  endtask

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------
  initial
  begin : main
    integer                 i;
    logic                   model_held;   // A transfer sits in the holding register
    logic                   load_now;     // Address phase taken at the next edge
    logic [`AHB_SIZE_W-1:0] cap_size;     // Sideband fields of the captured beat
    logic [`AHB_PROT_W-1:0] cap_prot;
    logic                   cap_lock;
    hsel_s      = 1'b0;
    haddr_s     = '0;
    htrans_s    = IDLE;
    hwrite_s    = 1'b0;
    hsize_s     = 3'd2;
    hburst_s    = SINGLE;
    hprot_s     = '0;
    hmaster_s   = '0;
    hmastlock_s = 1'b0;
    hready_s    = 1'b1;
    active_ip   = 1'b1;
    readyout_ip = 1'b1;
    resp_ip     = OKAY;
    check_en    = 1'b0;
    test_name   = '0;
    model_held  = 1'b0;               // Nothing held after reset
    cap_size    = '0;
    cap_prot    = '0;
    cap_lock    = 1'b0;
    read_vectors();
    vectors_loaded = 1'b1;
    wait (HRESETn === 1'b1);
    for (i = 0; i < nvec; i = i + 1)
    begin
      @(posedge HCLK);
      hsel_s      <= v_f[i][0][0];
      haddr_s     <= v_f[i][1][`AHB_ADDR_W-1:0];
      htrans_s    <= htrans_t'(v_f[i][2][1:0]);
      hwrite_s    <= v_f[i][3][0];
      hsize_s     <= v_f[i][4][`AHB_SIZE_W-1:0];
      hburst_s    <= hburst_t'(v_f[i][5][2:0]);
      hprot_s     <= v_f[i][6][`AHB_PROT_W-1:0];
      hmaster_s   <= v_f[i][7][`AHB_MASTER_W-1:0];
      hmastlock_s <= v_f[i][8][0];
      hready_s    <= v_f[i][9][0];
      active_ip   <= v_f[i][10][0];
      readyout_ip <= v_f[i][11][0];
      resp_ip     <= hresp_t'(v_f[i][12][1:0]);
      exp_hreadyout <= v_f[i][13][0];
      exp_hresp     <= v_f[i][14][1:0];
      exp_sel       <= v_f[i][15][0];
      exp_addr      <= v_f[i][16];
      exp_trans     <= v_f[i][17][1:0];
      exp_write     <= v_f[i][18][0];
      exp_burst     <= v_f[i][19][2:0];
      exp_master    <= v_f[i][20][3:0];
      exp_held      <= v_f[i][21][0];
      // Sideband fields come from the captured beat while it is held
      exp_size      <= model_held ? cap_size : v_f[i][4][`AHB_SIZE_W-1:0];
      exp_prot      <= model_held ? cap_prot : v_f[i][6][`AHB_PROT_W-1:0];
      exp_lock      <= model_held ? cap_lock : v_f[i][8][0];
      test_name     <= v_name[i];
      check_en      <= 1'b1;
      // Holding register as seen after the next edge
      load_now = v_f[i][0][0] && v_f[i][2][1] && v_f[i][9][0];
      if (load_now)
      begin
        cap_size = v_f[i][4][`AHB_SIZE_W-1:0];
        cap_prot = v_f[i][6][`AHB_PROT_W-1:0];
        cap_lock = v_f[i][8][0];
      end
      if (load_now && !v_f[i][10][0])
        model_held = 1'b1;             // Output stage busy with another port
      else if (v_f[i][10][0] && v_f[i][11][0])
        model_held = 1'b0;             // Held beat accepted downstream
    end
    @(posedge HCLK);
    check_en <= 1'b0;
    @(posedge HCLK);
    u_checker.print_summary();
    if (u_checker.err_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // Watchdog sized from the vector count plus reset and margin
  initial
  begin
    wait (vectors_loaded === 1'b1);
    #((nvec + 3 + 10) * 40);
    $display("Timeout: the run did not finish in the expected time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/tb_checker.sv */
`default_nettype none

// Compares the DUT outputs with the expected values from the stimulus side
module tb_checker
(
  input  wire                HCLK,
  input  wire                check_en,      // Expected values are valid
  input  wire [8*24-1:0]     test_name,
  input  wire                exp_hreadyout,
  input  wire [1:0]          exp_hresp,
  input  wire                exp_sel,
  input  wire [31:0]         exp_addr,
  input  wire [1:0]          exp_trans,
  input  wire                exp_write,
  input  wire [2:0]          exp_size,
  input  wire [2:0]          exp_burst,
  input  wire [3:0]          exp_prot,
  input  wire [3:0]          exp_master,
  input  wire                exp_lock,
  input  wire                exp_held,
  input  wire                hreadyout_s,
  input  wire [1:0]          hresp_s,
  input  wire                sel_ip,
  input  wire [31:0]         addr_ip,
  input  wire [1:0]          trans_ip,
  input  wire                write_ip,
  input  wire [2:0]          size_ip,
  input  wire [2:0]          burst_ip,
  input  wire [3:0]          prot_ip,
  input  wire [3:0]          master_ip,
  input  wire                mastlock_ip,
  input  wire                held_tran_ip
);

  integer err_count   = 0;
  integer check_count = 0;

  // ------------------------------------------------
  // Compare helpers
  // ------------------------------------------------
  task automatic compare_field(input [8*16-1:0] sig, input [31:0] exp_v, input [31:0] act_v);
    check_count = check_count + 1;
    if (exp_v !== act_v)                 // Also catches X and Z
    begin
      err_count = err_count + 1;
      $display("ERROR %0s %0s expected %h actual %h", test_name, sig, exp_v, act_v);
    end
  endtask

  // Failures that are not a wrong value
  task automatic report_problem(input [8*64-1:0] msg);
    err_count = err_count + 1;
    $display("Problem in the test run: %0s", msg);
  endtask

  task automatic print_summary;
    $display("Checks: %0d  Errors: %0d", check_count, err_count);
  endtask

  // Outputs are settled half a cycle after the drive edge
  always @(negedge HCLK)
  begin
    if (check_en)
    begin
      compare_field("hreadyout_s", exp_hreadyout, hreadyout_s);
      compare_field("hresp_s", exp_hresp, hresp_s);
      compare_field("sel_ip", exp_sel, sel_ip);
      compare_field("addr_ip", exp_addr, addr_ip);
      compare_field("trans_ip", exp_trans, trans_ip);
      compare_field("write_ip", exp_write, write_ip);
      compare_field("size_ip", exp_size, size_ip);
      compare_field("burst_ip", exp_burst, burst_ip);
      compare_field("prot_ip", exp_prot, prot_ip);
      compare_field("master_ip", exp_master, master_ip);
      compare_field("mastlock_ip", exp_lock, mastlock_ip);
      compare_field("held_tran_ip", exp_held, held_tran_ip);
    end
  end

endmodule

`default_nettype wire

/* tests/tb_clk_gen.sv */
`default_nettype none

// Clock and reset source for the testbench
module tb_clk_gen
(
  output logic HCLK,
  output logic HRESETn
);

  localparam int HALF_PERIOD = 20;   // 40 per cycle

  initial
  begin
    HCLK = 1'b0;
    forever #HALF_PERIOD HCLK = ~HCLK;
  end

  // Reset low for the first 3 rising edges
  initial
  begin
    HRESETn = 1'b0;
    repeat (3) @(posedge HCLK);
    HRESETn <= 1'b1;
  end

endmodule

`default_nettype wire

/* verilog/ahb_in_burst_fix.sv */
`default_nettype none

`include "ahb_in_macros.svh"

// Early burst termination and wrap boundary detection
module ahb_in_burst_fix
  import ahb_in_pkg::*;
(
  input  wire                    HCLK,
  input  wire                    HRESETn,
  input  wire                    load_reg,
  input  wire                    active_ip,
  input  wire                    hready_s,
  input  htrans_t                htrans_s,
  input  wire [`AHB_SIZE_W-1:0]  hsize_s,
  input  hburst_t                hburst_s,
  input  wire [`AHB_ADDR_W-1:0]  haddr_s,
  input  htrans_t                trans_int,   // From the output mux
  input  hburst_t                burst_int,
  input  htrans_t                trans_b,
  output htrans_t                trans_ip,
  output hburst_t                burst_ip
);

  logic                        burst_override;  // Burst was interrupted
  logic                        bound;           // Last beat hit wrap boundary
  logic [`AHB_WRAP_CHK_W-1:0]  offset_addr;     // Beat index in the burst
  logic [`AHB_WRAP_CHK_W-1:0]  check_addr;      // Offset padded with ones
  logic                        bound_next;

  // ------------------------------------------------
  // Burst override flag
  // ------------------------------------------------
  // A SEQ beat taken while another port owns the output stage
  // means the rest of the burst goes out as INCR
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      burst_override <= 1'b0;
    else if (hready_s)
    begin
      if (htrans_s == NONSEQ || htrans_s == IDLE)
        burst_override <= 1'b0;        // New burst or end of burst
      else if (htrans_s == SEQ && load_reg && !active_ip)
        burst_override <= 1'b1;
    end
  end

  // ------------------------------------------------
  // Boundary check
  // ------------------------------------------------
  always_comb
  begin
    case (hsize_s)
      3'd0:    offset_addr = haddr_s[`AHB_WRAP_CHK_W-1:0];   // Byte
      3'd1:    offset_addr = haddr_s[`AHB_WRAP_CHK_W:1];     // Halfword
      3'd2:    offset_addr = haddr_s[`AHB_WRAP_CHK_W+1:2];   // Word
      3'd3:    offset_addr = haddr_s[`AHB_WRAP_CHK_W+2:3];   // Doubleword
      default: offset_addr = haddr_s[`AHB_WRAP_CHK_W-1:0];   // Wide sizes use byte offset
    endcase
  end

  // Bits beyond the wrap length forced high
  always_comb
  begin
    check_addr = '0;                   // Incrementing bursts never wrap
    case (hburst_s)
      WRAP4:
      begin
        check_addr[1:0] = offset_addr[1:0];
        check_addr[3:2] = 2'b11;
      end
      WRAP8:
      begin
        check_addr[2:0] = offset_addr[2:0];
        check_addr[3]   = 1'b1;
      end
      WRAP16:
        check_addr = offset_addr;
      default:
        check_addr = '0;
    endcase
  end

  assign bound_next = (check_addr == {`AHB_WRAP_CHK_W{1'b1}});   // Last beat before wrap

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (htrans_s[1] && hready_s)  // Active beats only
      bound <= bound_next;
  end

  // ------------------------------------------------
  // HTRANS and HBURST rewrite
  // ------------------------------------------------
  always_comb
  begin
    trans_ip = trans_int;
    if (burst_override && bound)
    begin
      if (trans_int == SEQ)
        trans_ip = NONSEQ;             // Wrapped address restarts
      else if (trans_int == BUSY)
        trans_ip = IDLE;
    end
  end

  assign burst_ip = (burst_override && trans_b != NONSEQ) ? INCR : burst_int;

endmodule

`default_nettype wire

/* verilog/ahb_in_hold_reg.sv */
`default_nettype none

`include "ahb_in_macros.svh"

// Holding register plus the direct/held mux toward the output stage
module ahb_in_hold_reg
  import ahb_in_pkg::*;
(
  input  wire                       HCLK,
  input  wire                       HRESETn,
  input  wire                       load_reg,       // Capture strobe
  input  wire                       pend_tran_reg,  // Held transfer pending
  input  wire                       hsel_s,
  input  wire [`AHB_ADDR_W-1:0]     haddr_s,
  input  htrans_t                   htrans_s,
  input  wire                       hwrite_s,
  input  wire [`AHB_SIZE_W-1:0]     hsize_s,
  input  hburst_t                   hburst_s,
  input  wire [`AHB_PROT_W-1:0]     hprot_s,
  input  wire [`AHB_MASTER_W-1:0]   hmaster_s,
  input  wire                       hmastlock_s,
  output logic                      sel_ip,
  output logic [`AHB_ADDR_W-1:0]    addr_ip,
  output logic                      write_ip,
  output logic [`AHB_SIZE_W-1:0]    size_ip,
  output logic [`AHB_PROT_W-1:0]    prot_ip,
  output logic [`AHB_MASTER_W-1:0]  master_ip,
  output logic                      mastlock_ip,
  output htrans_t                   trans_int,      // Before burst fix
  output hburst_t                   burst_int,      // Before burst fix
  output htrans_t                   trans_b         // For burst type decision
);

  // ------------------------------------------------
  // Holding register
  // ------------------------------------------------
  htrans_t                  reg_trans;     // Held HTRANS
  logic [`AHB_ADDR_W-1:0]   reg_addr;
  logic                     reg_write;
  logic [`AHB_SIZE_W-1:0]   reg_size;
  hburst_t                  reg_burst;
  logic [`AHB_PROT_W-1:0]   reg_prot;
  logic [`AHB_MASTER_W-1:0] reg_master;
  logic                     reg_mastlock;

  // Transfer type of the captured beat
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      reg_trans <= IDLE;
    else if (load_reg)
      reg_trans <= htrans_s;
  end

  // Address and control fields
  always_ff @(posedge HCLK)
  begin
    if (load_reg)
    begin
      reg_addr     <= haddr_s;
      reg_write    <= hwrite_s;
      reg_size     <= hsize_s;
      reg_burst    <= hburst_s;
      reg_prot     <= hprot_s;
      reg_master   <= hmaster_s;
      reg_mastlock <= hmastlock_s;
    end
  end

  // ------------------------------------------------
  // Output mux
  // ------------------------------------------------
  always_comb
  begin
    if (pend_tran_reg)
    begin
      sel_ip      = 1'b1;          // Held transfer always selects
      trans_int   = NONSEQ;        // Replayed as a fresh transfer
      addr_ip     = reg_addr;
      write_ip    = reg_write;
      size_ip     = reg_size;
      burst_int   = reg_burst;
      prot_ip     = reg_prot;
      master_ip   = reg_master;
      mastlock_ip = reg_mastlock;
      trans_b     = reg_trans;     // Original type of the held beat
    end
    else
    begin
      sel_ip      = hsel_s;        // Straight through
      trans_int   = htrans_s;
      addr_ip     = haddr_s;
      write_ip    = hwrite_s;
      size_ip     = hsize_s;
      burst_int   = hburst_s;
      prot_ip     = hprot_s;
      master_ip   = hmaster_s;
      mastlock_ip = hmastlock_s;
      trans_b     = htrans_s;
    end
  end

endmodule

`default_nettype wire

/* verilog/ahb_in_macros.svh */
`ifndef AHB_IN_MACROS_SVH
`define AHB_IN_MACROS_SVH

// Bus widths of the slave port

// Address bus
`define AHB_ADDR_W 32

// HSIZE field
`define AHB_SIZE_W 3

// HPROT field
`define AHB_PROT_W 4

// HMASTER field
`define AHB_MASTER_W 4

// Beat offset for the wrap check
// Covers up to 16 beats
`define AHB_WRAP_CHK_W 4

`endif

/* verilog/ahb_in_pkg.sv */
`default_nettype none

// Bus encodings shared by the input stage blocks
package ahb_in_pkg;

  // ------------------------------------------------
  // HTRANS transfer type
  // ------------------------------------------------
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Master inserting a wait in a burst
    NONSEQ = 2'b10,  // First beat or single
    SEQ    = 2'b11   // Following beats of a burst
  } htrans_t;

  // ------------------------------------------------
  // HBURST burst type
  // ------------------------------------------------
  typedef enum logic [2:0]
  {
    SINGLE = 3'b000,  // Single transfer
    INCR   = 3'b001,  // Undefined length incrementing
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_t;

  // ------------------------------------------------
  // HRESP response
  // ------------------------------------------------
  typedef enum logic [1:0]
  {
    OKAY  = 2'b00,  // Transfer done or still waiting
    ERROR = 2'b01   // Slave error, two-cycle response
  } hresp_t;

endpackage

`default_nettype wire

/* verilog/ahb_in_stage.sv */
`default_nettype none

`include "ahb_in_macros.svh"

// Input stage of one slave port on the bus matrix
module ahb_in_stage
  import ahb_in_pkg::*;
(
  input  wire                       HCLK,
  input  wire                       HRESETn,
  // Upstream address phase
  input  wire                       hsel_s,
  input  wire [`AHB_ADDR_W-1:0]     haddr_s,
  input  htrans_t                   htrans_s,
  input  wire                       hwrite_s,
  input  wire [`AHB_SIZE_W-1:0]     hsize_s,
  input  hburst_t                   hburst_s,
  input  wire [`AHB_PROT_W-1:0]     hprot_s,
  input  wire [`AHB_MASTER_W-1:0]   hmaster_s,
  input  wire                       hmastlock_s,
  input  wire                       hready_s,
  // From the output stage
  input  wire                       active_ip,
  input  wire                       readyout_ip,
  input  hresp_t                    resp_ip,
  // Response to the master
  output wire                       hreadyout_s,
  output hresp_t                    hresp_s,
  // Toward the output stage
  output wire                       sel_ip,
  output wire [`AHB_ADDR_W-1:0]     addr_ip,
  output htrans_t                   trans_ip,
  output wire                       write_ip,
  output wire [`AHB_SIZE_W-1:0]     size_ip,
  output hburst_t                   burst_ip,
  output wire [`AHB_PROT_W-1:0]     prot_ip,
  output wire [`AHB_MASTER_W-1:0]   master_ip,
  output wire                       mastlock_ip,
  output wire                       held_tran_ip
);

  wire     load_reg;
  wire     pend_tran_reg;
  htrans_t trans_int;
  hburst_t burst_int;
  htrans_t trans_b;

  ahb_in_tran_ctrl u_tran_ctrl (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .hsel_s        (hsel_s),
    .htrans_s      (htrans_s),
    .hready_s      (hready_s),
    .active_ip     (active_ip),
    .readyout_ip   (readyout_ip),
    .resp_ip       (resp_ip),
    .load_reg      (load_reg),
    .pend_tran_reg (pend_tran_reg),
    .held_tran_ip  (held_tran_ip),
    .hreadyout_s   (hreadyout_s),
    .hresp_s       (hresp_s)
  );

  ahb_in_hold_reg u_hold_reg (
    .HCLK(HCLK), .HRESETn(HRESETn), .load_reg(load_reg), .pend_tran_reg(pend_tran_reg),
    .hsel_s(hsel_s), .haddr_s(haddr_s), .htrans_s(htrans_s), .hwrite_s(hwrite_s),
    .hsize_s(hsize_s), .hburst_s(hburst_s), .hprot_s(hprot_s), .hmaster_s(hmaster_s),
    .hmastlock_s(hmastlock_s), .sel_ip(sel_ip), .addr_ip(addr_ip), .write_ip(write_ip),
    .size_ip(size_ip), .prot_ip(prot_ip), .master_ip(master_ip),
    .mastlock_ip(mastlock_ip), .trans_int(trans_int), .burst_int(burst_int),
    .trans_b(trans_b)
  );

  ahb_in_burst_fix u_burst_fix (
    .HCLK(HCLK), .HRESETn(HRESETn), .load_reg(load_reg), .active_ip(active_ip),
    .hready_s(hready_s), .htrans_s(htrans_s), .hsize_s(hsize_s), .hburst_s(hburst_s),
    .haddr_s(haddr_s), .trans_int(trans_int), .burst_int(burst_int), .trans_b(trans_b),
    .trans_ip(trans_ip), .burst_ip(burst_ip)
  );

endmodule

`default_nettype wire

/* verilog/ahb_in_tran_ctrl.sv */
`default_nettype none

// Load strobe, pending flag and the response back to the master
module ahb_in_tran_ctrl
  import ahb_in_pkg::*;
(
  input  wire     HCLK,
  input  wire     HRESETn,
  input  wire     hsel_s,
  input  htrans_t htrans_s,
  input  wire     hready_s,
  input  wire     active_ip,      // Output stage is driving this port
  input  wire     readyout_ip,    // Ready from the shared slave
  input  hresp_t  resp_ip,        // Response from the shared slave
  output logic    load_reg,       // Capture this address phase
  output logic    pend_tran_reg,  // Transfer waiting in holding register
  output logic    held_tran_ip,   // Request to the arbiter
  output logic    hreadyout_s,
  output hresp_t  hresp_s
);

  logic addr_valid;   // Selected NONSEQ or SEQ
  logic data_valid;   // Data phase of a valid transfer

  // ------------------------------------------------
  // Address phase decode
  // ------------------------------------------------
  assign addr_valid = hsel_s & htrans_s[1];     // Upper bit means active
  assign load_reg   = addr_valid & hready_s;

  // Follows the address phase into the data phase
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (hready_s)
      data_valid <= addr_valid;
  end

  // ------------------------------------------------
  // Pending transfer
  // ------------------------------------------------
  // Set when the output stage is busy elsewhere
  // Cleared once the held beat is accepted downstream
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_tran_reg <= 1'b0;
    else if (load_reg && !active_ip)
      pend_tran_reg <= 1'b1;
    else if (active_ip && readyout_ip)
      pend_tran_reg <= 1'b0;
  end

  assign held_tran_ip = load_reg | pend_tran_reg;   // Live or held request

  // Response mux
  always_comb
  begin
    if (!data_valid)
    begin
      hreadyout_s = 1'b1;            // Idle, busy or not selected
      hresp_s     = OKAY;
    end
    else if (pend_tran_reg)
    begin
      hreadyout_s = 1'b0;            // Stall while held
      hresp_s     = OKAY;
    end
    else
    begin
      hreadyout_s = readyout_ip;     // From the shared slave
      hresp_s     = resp_ip;
    end
  end

endmodule

`default_nettype wire
